// ==== dcache.f ====
hdl/dcache_pkg.sv
hdl/bridge_pkg.sv
hdl/sram_1rw.sv
hdl/dcache_store_buffer.sv
hdl/dcache_refill.sv
hdl/dcache.sv
tb/bus_mem_model.sv
tb/dcache_tb.sv

// ==== hdl/bridge_pkg.sv ====
package bridge_pkg;

    // every transfer moves one whole line
    localparam int beats_per_line = dcache_pkg::words_per_line;

    typedef logic [$clog2(beats_per_line)-1:0] beat_cnt_t;

    typedef struct packed {
        logic req;
        dcache_pkg::addr_t addr;
    } bus_rd_t;

    typedef struct packed {
        logic req;
        dcache_pkg::addr_t addr;
        dcache_pkg::line_t data;
    } bus_wr_t;

    typedef struct packed {
        logic valid;
        logic last;
        dcache_pkg::word_t data;
    } bus_ret_t;

    // byte address of the first word of a line
    function automatic dcache_pkg::addr_t line_addr(dcache_pkg::tag_t tag,
                                                   dcache_pkg::index_t index);
        return {tag, index, {(dcache_pkg::bank_bits + dcache_pkg::offset_bits){1'b0}}};
    endfunction

endpackage

// ==== hdl/dcache.sv ====
`timescale 1ns/1ns

module dcache (
    input logic clock,
    input logic reset,
    input logic valid,
    output logic ready,
    input dcache_pkg::cpu_req_t cpu_req,
    output logic rvalid,
    output logic rhit,
    output logic whit,
    output dcache_pkg::word_t rdata,
    output bridge_pkg::bus_rd_t rd,
    input logic rd_rdy,
    input bridge_pkg::bus_ret_t ret,
    output bridge_pkg::bus_wr_t wr,
    input logic wr_rdy
);
    import dcache_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_lookup,
        st_miss
    } state_t;

    state_t state;
    cpu_req_t req_q;
    addr_fields_t in_f;
    addr_fields_t req_f;
    // sets written since reset, the tag memory itself powers up unknown
    logic [num_sets-1:0] valid_q;
    logic [num_sets-1:0] dirty_q;

    logic accept;
    logic lookup_hit;
    index_t sram_index;
    tagv_t tagv_rd;
    tagv_t tagv_wdata;
    tagv_t line_tagv;
    word_t bank_rd [words_per_line];
    word_t hit_word;
    line_t victim_line;

    logic sb_active;
    store_entry_t sb_entry;
    store_entry_t sb_entry_in;
    logic stall;
    logic fwd_hit;
    word_t fwd_data;

    logic fill_done;
    line_t fill_line;
    logic load_valid;
    word_t load_data;

    assign in_f = cpu_req.addr;
    assign req_f = req_q.addr;
    assign accept = valid && ready;

    // an accepted request reads its own set, otherwise hold the buffered one
    assign sram_index = accept ? in_f.index : req_f.index;

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
            valid_q <= '0;
            dirty_q <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (accept) begin
                        state <= st_lookup;
                    end
                end
                st_lookup: begin
                    if (!lookup_hit) begin
                        state <= st_miss;
                    end else if (!accept) begin
                        state <= st_idle;
                    end
                end
                st_miss: begin
                    if (fill_done) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
            if (whit) begin
                dirty_q[req_f.index] <= 1'b1;
            end
            // new line is dirty only when a store allocated it
            if (fill_done) begin
                valid_q[req_f.index] <= 1'b1;
                dirty_q[req_f.index] <= req_q.op;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            req_q <= cpu_req;
        end
    end

    // lookup
    assign line_tagv.valid = valid_q[req_f.index] && tagv_rd.valid;
    assign line_tagv.tag = tagv_rd.tag;
    assign lookup_hit = line_tagv.valid && (line_tagv.tag == req_f.tag);
    assign hit_word = fwd_hit ? fwd_data : bank_rd[req_f.bank];

    assign ready = ((state == st_idle) || (state == st_lookup && lookup_hit)) && !stall;
    assign rhit = (state == st_lookup) && lookup_hit && !req_q.op;
    assign whit = (state == st_lookup) && lookup_hit && req_q.op;
    assign rvalid = rhit || load_valid;
    assign rdata = (state == st_lookup) ? hit_word : load_data;

    // tag memory is written only when a refill completes
    assign tagv_wdata.valid = 1'b1;
    assign tagv_wdata.tag = req_f.tag;

    sram_1rw #(
        .payload_t(tagv_t)
    ) tagv_ram (
        .clock(clock),
        .write(fill_done),
        .addr(sram_index),
        .wdata(tagv_wdata),
        .rdata(tagv_rd)
    );

    for (genvar j = 0; j < words_per_line; j++) begin : g_bank
        logic sb_sel;
        index_t bank_addr;
        word_t bank_wdata;

        // pending store owns this bank port for one cycle
        assign sb_sel = sb_active && (sb_entry.bank == bank_t'(j));
        assign bank_addr = sb_sel ? sb_entry.index : sram_index;
        assign bank_wdata = sb_sel ? sb_entry.data : fill_line[j*word_bits +: word_bits];

        sram_1rw #(
            .payload_t(word_t)
        ) data_ram (
            .clock(clock),
            .write(sb_sel || fill_done),
            .addr(bank_addr),
            .wdata(bank_wdata),
            .rdata(bank_rd[j])
        );
    end

    always_comb begin
        for (int w = 0; w < words_per_line; w++) begin
            victim_line[w*word_bits +: word_bits] = bank_rd[w];
        end
    end

    // hit stores merge into the current word before buffering
    assign sb_entry_in.tag = req_f.tag;
    assign sb_entry_in.index = req_f.index;
    assign sb_entry_in.bank = req_f.bank;
    assign sb_entry_in.data = merge_word(hit_word, req_q.wdata, req_q.awstrb);

    dcache_store_buffer store_buffer_inst (
        .clock(clock),
        .reset(reset),
        .accept(whit),
        .entry_in(sb_entry_in),
        .probe_bank(in_f.bank),
        .lookup_tag(req_f.tag),
        .lookup_index(req_f.index),
        .lookup_bank(req_f.bank),
        .active(sb_active),
        .entry(sb_entry),
        .stall(stall),
        .fwd_hit(fwd_hit),
        .fwd_data(fwd_data)
    );

    dcache_refill refill_inst (
        .clock(clock),
        .reset(reset),
        .start((state == st_lookup) && !lookup_hit),
        .need_writeback(line_tagv.valid && dirty_q[req_f.index]),
        .req(req_q),
        .victim(line_tagv),
        .victim_line(victim_line),
        .rd(rd),
        .rd_rdy(rd_rdy),
        .ret(ret),
        .wr(wr),
        .wr_rdy(wr_rdy),
        .fill_done(fill_done),
        .fill_line(fill_line),
        .load_valid(load_valid),
        .load_data(load_data)
    );

endmodule

// ==== hdl/dcache_pkg.sv ====
package dcache_pkg;

    // geometry of the direct-mapped array
    localparam int num_sets = 256;
    localparam int words_per_line = 4;
    localparam int word_bits = 32;
    localparam int index_bits = $clog2(num_sets);
    localparam int bank_bits = $clog2(words_per_line);
    // byte within a word
    localparam int offset_bits = 2;
    localparam int tag_bits = word_bits - index_bits - bank_bits - offset_bits;

    typedef logic [word_bits-1:0] addr_t;
    typedef logic [word_bits-1:0] word_t;
    typedef logic [word_bits/8-1:0] strobe_t;
    typedef logic [tag_bits-1:0] tag_t;
    typedef logic [index_bits-1:0] index_t;
    typedef logic [bank_bits-1:0] bank_t;
    // word 0 sits in the lowest bits
    typedef logic [words_per_line*word_bits-1:0] line_t;

    // a byte address split into its cache fields
    typedef struct packed {
        tag_t tag;
        index_t index;
        bank_t bank;
        logic [offset_bits-1:0] offset;
    } addr_fields_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tagv_t;

    // op is 0 for a load, 1 for a store
    typedef struct packed {
        logic op;
        addr_t addr;
        strobe_t awstrb;
        word_t wdata;
    } cpu_req_t;

    typedef struct packed {
        tag_t tag;
        index_t index;
        bank_t bank;
        word_t data;
    } store_entry_t;

    // bytes of new_word replace those of old_word where the strobe is set
    function automatic word_t merge_word(word_t old_word, word_t new_word, strobe_t strobe);
        word_t merged;
        for (int b = 0; b < $bits(strobe_t); b++) begin
            merged[b*8 +: 8] = strobe[b] ? new_word[b*8 +: 8] : old_word[b*8 +: 8];
        end
        return merged;
    endfunction

endpackage

// ==== hdl/dcache_refill.sv ====
`timescale 1ns/1ns

module dcache_refill (
    input logic clock,
    input logic reset,
    input logic start,
    input logic need_writeback,
    // buffered request, held by the top for the whole miss
    input dcache_pkg::cpu_req_t req,
    input dcache_pkg::tagv_t victim,
    input dcache_pkg::line_t victim_line,
    output bridge_pkg::bus_rd_t rd,
    input logic rd_rdy,
    input bridge_pkg::bus_ret_t ret,
    output bridge_pkg::bus_wr_t wr,
    input logic wr_rdy,
    output logic fill_done,
    output dcache_pkg::line_t fill_line,
    output logic load_valid,
    output dcache_pkg::word_t load_data
);
    import dcache_pkg::*;
    import bridge_pkg::*;

    typedef enum logic [1:0] {
        rf_idle,
        rf_writeback,
        rf_read,
        rf_receive
    } refill_state_t;

    refill_state_t state;
    addr_fields_t req_f;
    beat_cnt_t beat;
    logic wb_settled;
    logic last_beat;
    // first beats of the line, the final one is taken straight off the bus
    word_t beat_buf [words_per_line-1];
    word_t fill_words [words_per_line];

    assign req_f = req.addr;
    assign last_beat = ret.last || (beat == beat_cnt_t'(beats_per_line - 1));

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= rf_idle;
            beat <= '0;
            wb_settled <= 1'b0;
        end else begin
            case (state)
                rf_idle: begin
                    wb_settled <= 1'b0;
                    if (start) begin
                        state <= need_writeback ? rf_writeback : rf_read;
                    end
                end
                rf_writeback: begin
                    // victim line is stable from the second cycle on
                    wb_settled <= 1'b1;
                    if (wb_settled && wr_rdy) begin
                        state <= rf_read;
                    end
                end
                rf_read: begin
                    if (rd_rdy) begin
                        state <= rf_receive;
                        beat <= '0;
                    end
                end
                rf_receive: begin
                    if (ret.valid) begin
                        beat <= beat + 1'b1;
                        if (last_beat) begin
                            state <= rf_idle;
                        end
                    end
                end
                default: begin
                    state <= rf_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (state == rf_receive && ret.valid && !last_beat) begin
            beat_buf[beat] <= ret.data;
        end
    end

    // assemble the line, store data goes over the requested word
    for (genvar w = 0; w < words_per_line; w++) begin : g_word
        word_t raw;
        if (w == words_per_line - 1) begin : g_bus
            assign raw = ret.data;
        end else begin : g_buf
            assign raw = beat_buf[w];
        end
        assign fill_words[w] = (req.op && req_f.bank == bank_t'(w))
            ? merge_word(raw, req.wdata, req.awstrb) : raw;
    end

    always_comb begin
        for (int w = 0; w < words_per_line; w++) begin
            fill_line[w*word_bits +: word_bits] = fill_words[w];
        end
    end

    assign fill_done = (state == rf_receive) && ret.valid && last_beat;

    // a load gets its word as it passes by
    assign load_valid = (state == rf_receive) && ret.valid && !req.op
        && (beat == beat_cnt_t'(req_f.bank));
    assign load_data = ret.data;

    assign rd.req = (state == rf_read);
    assign rd.addr = line_addr(req_f.tag, req_f.index);

    assign wr.req = (state == rf_writeback) && wb_settled;
    assign wr.addr = line_addr(victim.tag, req_f.index);
    assign wr.data = victim_line;

endmodule

// ==== hdl/dcache_store_buffer.sv ====
`timescale 1ns/1ns

module dcache_store_buffer (
    input logic clock,
    input logic reset,
    input logic accept,
    input dcache_pkg::store_entry_t entry_in,
    // bank of the request arriving at the cpu port
    input dcache_pkg::bank_t probe_bank,
    // fields of the request now in lookup
    input dcache_pkg::tag_t lookup_tag,
    input dcache_pkg::index_t lookup_index,
    input dcache_pkg::bank_t lookup_bank,
    output logic active,
    output dcache_pkg::store_entry_t entry,
    output logic stall,
    output logic fwd_hit,
    output dcache_pkg::word_t fwd_data
);
    import dcache_pkg::*;

    // entry lives for one cycle unless a new hit store replaces it
    always_ff @(posedge clock) begin
        if (reset) begin
            active <= 1'b0;
        end else begin
            active <= accept;
        end
    end

    always_ff @(posedge clock) begin
        if (accept) begin
            entry <= entry_in;
        end
    end

    // the bank port is busy with the buffered write this cycle
    assign stall = active && (probe_bank == entry.bank);

    // lookup read the array before this store landed
    assign fwd_hit = active
        && (lookup_tag == entry.tag)
        && (lookup_index == entry.index)
        && (lookup_bank == entry.bank);

    // word is already merged with the old line contents
    assign fwd_data = entry.data;

endmodule

// ==== hdl/sram_1rw.sv ====
`timescale 1ns/1ns

module sram_1rw #(
    parameter type payload_t = logic [31:0]
) (
    input logic clock,
    input logic write,
    input dcache_pkg::index_t addr,
    input payload_t wdata,
    output payload_t rdata
);
    import dcache_pkg::*;

    // one entry per set
    payload_t mem [num_sets];

    // read-first: a write in the same cycle shows up on the next read
    always_ff @(posedge clock) begin
        if (write) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build the dcache testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ns --top-module dcache_tb \
    -f dcache.f -o dcache_sim &&
out="$(./obj_dir/dcache_sim)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx 'TB PASSED' &&
echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== tb/bus_mem_model.sv ====
`timescale 1ns/1ns

module bus_mem_model (
    input logic clock,
    input logic reset,
    input bridge_pkg::bus_rd_t rd,
    output logic rd_rdy,
    output bridge_pkg::bus_ret_t ret,
    input bridge_pkg::bus_wr_t wr,
    output logic wr_rdy
);
    import dcache_pkg::*;
    import bridge_pkg::*;

    // cycles a request waits before it is taken
    localparam int req_wait = 2;

    // only written words are kept, all others follow the fill pattern
    word_t mem [addr_t];
    int rd_wait;
    int wr_wait;
    logic sending;
    addr_t send_addr;
    beat_cnt_t send_beat;

    function automatic word_t pattern_word(addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic word_t read_word(addr_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return pattern_word(a);
    endfunction

    initial begin
        rd_rdy = 1'b0;
        wr_rdy = 1'b0;
        ret = '0;
    end

    always @(posedge clock) begin
        if (reset) begin
            rd_rdy <= 1'b0;
            wr_rdy <= 1'b0;
            ret <= '0;
            rd_wait <= 0;
            wr_wait <= 0;
            sending <= 1'b0;
            send_beat <= '0;
        end else begin
            rd_rdy <= 1'b0;
            wr_rdy <= 1'b0;
            ret <= '0;
            if (rd.req && rd_rdy) begin
                sending <= 1'b1;
                send_addr <= rd.addr;
                send_beat <= '0;
                rd_wait <= 0;
            end else if (rd.req && !sending) begin
                if (rd_wait == req_wait) begin
                    rd_rdy <= 1'b1;
                end else begin
                    rd_wait <= rd_wait + 1;
                end
            end
            // about one beat in four is held back a cycle
            if (sending && $urandom_range(3) != 0) begin
                ret.valid <= 1'b1;
                ret.last <= (send_beat == 2'd3);
                ret.data <= read_word(send_addr + addr_t'({send_beat, 2'b00}));
                send_beat <= send_beat + 1'b1;
                if (send_beat == 2'd3) begin
                    sending <= 1'b0;
                end
            end
            if (wr.req && wr_rdy) begin
                for (int w = 0; w < words_per_line; w++) begin
                    mem[wr.addr + addr_t'(w * 4)] = wr.data[w*word_bits +: word_bits];
                end
                wr_wait <= 0;
            end else if (wr.req) begin
                if (wr_wait == req_wait) begin
                    wr_rdy <= 1'b1;
                end else begin
                    wr_wait <= wr_wait + 1;
                end
            end
        end
    end

endmodule

// ==== tb/dcache_tb.sv ====
`timescale 1ns/1ns

module dcache_tb;
    import dcache_pkg::*;
    import bridge_pkg::*;

    // roughly four times the cycles that all tests together take
    localparam int cycle_limit = 4000;
    localparam int wait_limit = 200;
    localparam tag_t tag_a = 20'h00012;
    localparam tag_t tag_b = 20'h0003c;
    localparam tag_t tag_c = 20'h00a05;

    typedef struct packed {
        word_t data;
        logic hit;
        int cyc;
    } rsp_t;

    logic clock;
    logic reset;
    logic valid;
    logic ready;
    cpu_req_t cpu_req;
    logic rvalid;
    logic rhit;
    logic whit;
    word_t rdata;
    bus_rd_t rd;
    logic rd_rdy;
    bus_ret_t ret;
    bus_wr_t wr;
    logic wr_rdy;

    int errors = 0;
    int cycles = 0;
    int acc_count = 0;
    int acc_cyc = 0;
    int rd_cyc = 0;
    addr_t rd_addr_seen = '0;
    rsp_t rsp_new;
    rsp_t rsp_q [$];
    int whit_q [$];
    bus_wr_t wb_q [$];
    // byte-level reference of what memory should hold
    logic [7:0] ref_mem [addr_t];

    dcache dcache_inst (
        .clock(clock),
        .reset(reset),
        .valid(valid),
        .ready(ready),
        .cpu_req(cpu_req),
        .rvalid(rvalid),
        .rhit(rhit),
        .whit(whit),
        .rdata(rdata),
        .rd(rd),
        .rd_rdy(rd_rdy),
        .ret(ret),
        .wr(wr),
        .wr_rdy(wr_rdy)
    );

    bus_mem_model mem_model_inst (
        .clock(clock),
        .reset(reset),
        .rd(rd),
        .rd_rdy(rd_rdy),
        .ret(ret),
        .wr(wr),
        .wr_rdy(wr_rdy)
    );

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // outputs are stable here, half a cycle after the inputs moved
    always @(negedge clock) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("timeout after %0d cycles with %0d errors so far", cycles, errors);
            $display("TB FAILED");
            $finish;
        end else if (!reset) begin
            if (valid && ready) begin
                acc_count++;
                acc_cyc = cycles;
            end
            if (rvalid) begin
                rsp_new.data = rdata;
                rsp_new.hit = rhit;
                rsp_new.cyc = cycles;
                rsp_q.push_back(rsp_new);
            end
            if (whit) begin
                whit_q.push_back(cycles);
            end
            if (rd.req && rd_rdy) begin
                rd_cyc = cycles;
                rd_addr_seen = rd.addr;
            end
            if (wr.req && wr_rdy) begin
                wb_q.push_back(wr);
            end
        end
    end

    function automatic word_t pattern_word(addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic addr_t make_addr(tag_t tag, index_t index, bank_t bank);
        return {tag, index, bank, 2'b00};
    endfunction

    function automatic word_t ref_word(addr_t a);
        addr_t base;
        word_t w;
        base = {a[31:2], 2'b00};
        w = pattern_word(base);
        for (int b = 0; b < 4; b++) begin
            if (ref_mem.exists(base + addr_t'(b))) begin
                w[b*8 +: 8] = ref_mem[base + addr_t'(b)];
            end
        end
        return w;
    endfunction

    task automatic ref_store(addr_t a, word_t data, strobe_t strb);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                ref_mem[{a[31:2], 2'b00} + addr_t'(b)] = data[b*8 +: 8];
            end
        end
    endtask

    function automatic logic whit_at(int cyc);
        foreach (whit_q[i]) begin
            if (whit_q[i] == cyc) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic compare_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_bit(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic compare_addr(string name, addr_t got, addr_t exp);
        if (got !== exp) begin
            $display("Error %s: got 0x%h, expected 0x%h", name, got, exp);
            errors++;
        end
    endtask

    // hold the request until the cache takes it, return on the accepting edge
    task automatic send(cpu_req_t r, output int stamp);
        int n0;
        int tries;
        #1;
        valid = 1'b1;
        cpu_req = r;
        n0 = acc_count;
        tries = 0;
        do begin
            @(posedge clock);
            tries++;
        end while (acc_count == n0 && tries < wait_limit);
        if (acc_count == n0) begin
            $display("request to address 0x%h was never accepted", r.addr);
            errors++;
        end
        stamp = acc_cyc;
    endtask

    task automatic release_port();
        #1;
        valid = 1'b0;
    endtask

    task automatic wait_response(output rsp_t r);
        int tries;
        tries = 0;
        do begin
            @(posedge clock);
            tries++;
        end while (rsp_q.size() == 0 && tries < wait_limit);
        if (rsp_q.size() == 0) begin
            $display("no read response arrived within %0d cycles", wait_limit);
            errors++;
            r = '0;
        end else begin
            r = rsp_q.pop_front();
        end
    endtask

    task automatic load_word(addr_t a, output rsp_t r, output int latency);
        cpu_req_t q;
        int stamp;
        q = '0;
        q.addr = a;
        send(q, stamp);
        release_port();
        wait_response(r);
        latency = r.cyc - stamp;
    endtask

    task automatic store_word(addr_t a, word_t data, strobe_t strb, output int stamp);
        cpu_req_t q;
        q.op = 1'b1;
        q.addr = a;
        q.awstrb = strb;
        q.wdata = data;
        send(q, stamp);
        release_port();
        ref_store(a, data, strb);
    endtask

    task automatic cold_load_miss();
        rsp_t r;
        int latency;
        load_word(make_addr(tag_a, 8'h21, 2'd1), r, latency);
        compare_word("rdata", r.data, ref_word(make_addr(tag_a, 8'h21, 2'd1)));
        compare_bit("rhit", r.hit, 1'b0);
        compare_addr("rd.addr", rd_addr_seen, make_addr(tag_a, 8'h21, 2'd0));
        // the word must show up after the line read was taken
        compare_bit("rvalid during refill", rd_cyc > r.cyc - latency && r.cyc > rd_cyc, 1'b1);
    endtask

    task automatic repeat_load_hit();
        rsp_t r;
        int latency;
        load_word(make_addr(tag_a, 8'h21, 2'd1), r, latency);
        compare_word("rdata", r.data, ref_word(make_addr(tag_a, 8'h21, 2'd1)));
        compare_bit("rhit", r.hit, 1'b1);
        compare_bit("rvalid one cycle after accept", latency == 1, 1'b1);
    endtask

    task automatic store_then_forward();
        cpu_req_t q;
        rsp_t r1;
        rsp_t r2;
        int st_stamp;
        int ld1_stamp;
        int ld2_stamp;
        addr_t a;
        a = make_addr(tag_a, 8'h21, 2'd2);
        q.op = 1'b1;
        q.addr = a;
        q.awstrb = 4'b0110;
        q.wdata = 32'hdead_beef;
        send(q, st_stamp);
        ref_store(a, q.wdata, q.awstrb);
        // two loads to the same word right behind the store
        q = '0;
        q.addr = a;
        send(q, ld1_stamp);
        send(q, ld2_stamp);
        release_port();
        wait_response(r1);
        wait_response(r2);
        compare_bit("whit", whit_at(st_stamp + 1), 1'b1);
        compare_word("rdata", r1.data, ref_word(a));
        compare_bit("rhit", r1.hit, 1'b1);
        compare_word("rdata", r2.data, ref_word(a));
        compare_bit("forwarded load accepted next cycle", ld1_stamp == st_stamp + 1, 1'b1);
        // second load hits the bank while the buffered store writes it
        compare_bit("bank stall", ld2_stamp == ld1_stamp + 2, 1'b1);
    endtask

    task automatic store_miss_allocate();
        rsp_t r;
        int latency;
        int stamp;
        addr_t a;
        a = make_addr(tag_a, 8'h47, 2'd3);
        store_word(a, 32'h1234_5678, 4'b1001, stamp);
        compare_bit("whit", whit_at(stamp + 1), 1'b0);
        for (int b = 0; b < 4; b++) begin
            load_word(make_addr(tag_a, 8'h47, bank_t'(b)), r, latency);
            compare_word("rdata", r.data, ref_word(make_addr(tag_a, 8'h47, bank_t'(b))));
            compare_bit("rhit", r.hit, 1'b1);
        end
    endtask

    task automatic dirty_victim_writeback();
        rsp_t r;
        int latency;
        int n0;
        bus_wr_t w;
        addr_t old_line;
        n0 = wb_q.size();
        old_line = make_addr(tag_a, 8'h47, 2'd0);
        load_word(make_addr(tag_b, 8'h47, 2'd0), r, latency);
        compare_word("rdata", r.data, ref_word(make_addr(tag_b, 8'h47, 2'd0)));
        if (wb_q.size() != n0 + 1) begin
            $display("expected one line write for the dirty victim, saw %0d", wb_q.size() - n0);
            errors++;
        end else begin
            w = wb_q.pop_back();
            compare_addr("wr.addr", w.addr, old_line);
            for (int i = 0; i < words_per_line; i++) begin
                compare_word("wr.data", w.data[i*word_bits +: word_bits],
                    ref_word(old_line + addr_t'(i * 4)));
            end
        end
    endtask

    task automatic random_mix();
        rsp_t r;
        int latency;
        int stamp;
        int pick;
        tag_t tag;
        index_t index;
        addr_t a;
        for (int n = 0; n < 200; n++) begin
            tag = ($urandom_range(1) == 0) ? tag_a : tag_c;
            pick = $urandom_range(2);
            index = (pick == 0) ? 8'h21 : (pick == 1) ? 8'h47 : 8'h90;
            a = make_addr(tag, index, bank_t'($urandom_range(3)));
            if ($urandom_range(1) == 1) begin
                store_word(a, word_t'($urandom()), strobe_t'($urandom_range(15, 1)), stamp);
            end else begin
                load_word(a, r, latency);
                compare_word("rdata", r.data, ref_word(a));
            end
        end
    endtask

    initial begin
        void'($urandom(95));
        reset = 1'b1;
        valid = 1'b0;
        cpu_req = '0;
        repeat (3) @(posedge clock);
        #1 reset = 1'b0;
        @(negedge clock);
        compare_bit("ready", ready, 1'b1);
        compare_bit("rd.req", rd.req, 1'b0);
        compare_bit("wr.req", wr.req, 1'b0);
        compare_bit("rvalid", rvalid, 1'b0);
        compare_bit("rhit", rhit, 1'b0);
        compare_bit("whit", whit, 1'b0);
        @(posedge clock);
        cold_load_miss();
        repeat_load_hit();
        store_then_forward();
        store_miss_allocate();
        dirty_victim_writeback();
        random_mix();
        $display("run finished after %0d cycles with %0d errors", cycles, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule
